// File: rtl/axi_pkg.sv
package axi_pkg;

  localparam int ID_W = 4;

  // beats minus one
  typedef logic [7:0] len_t;
  localparam len_t BEATS_ONE = 8'd0;

  typedef logic [1:0] burst_t;
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  // any nonzero response is reported to the requester as an error
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_EXOKAY = 2'b01;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

endpackage

// File: rtl/mem_pkg.sv
package mem_pkg;

  localparam int XLEN   = 32;
  localparam int ADDR_W = 32;
  localparam int STRB_W = XLEN / 8;  // one strobe per byte lane

  // same encoding as axsize
  typedef logic [2:0] size_t;
  localparam size_t SIZE_BYTE = 3'd0;
  localparam size_t SIZE_HALF = 3'd1;
  localparam size_t SIZE_WORD = 3'd2;

  // requester identity, goes out as the axi id
  typedef logic [3:0] req_id_t;
  localparam req_id_t ID_FETCH = 4'd0;
  localparam req_id_t ID_DATA  = 4'd1;

endpackage

// File: rtl/mem_port_arb.sv
module mem_port_arb (
  input  logic                       clk,
  input  logic                       rst_n_i,
  // fetch port, word reads only
  input  logic                       fetch_req_valid_i,
  input  logic [mem_pkg::ADDR_W-1:0] fetch_addr_i,
  output logic                       fetch_done_o,
  output logic [mem_pkg::XLEN-1:0]   fetch_rdata_o,
  output logic                       fetch_err_o,
  // data port
  input  logic                       data_req_valid_i,
  input  logic                       data_we_i,
  input  logic [mem_pkg::ADDR_W-1:0] data_addr_i,
  input  mem_pkg::size_t             data_size_i,
  input  logic [mem_pkg::XLEN-1:0]   data_wdata_i,
  input  logic [mem_pkg::STRB_W-1:0] data_wstrb_i,
  output logic                       data_done_o,
  output logic [mem_pkg::XLEN-1:0]   data_rdata_o,
  output logic                       data_err_o,
  // read master
  output logic                       rd_start_o,
  output logic [mem_pkg::ADDR_W-1:0] rd_addr_o,
  output mem_pkg::size_t             rd_size_o,
  output mem_pkg::req_id_t           rd_id_o,
  input  logic                       rd_done_i,
  input  logic [mem_pkg::XLEN-1:0]   rd_data_i,
  input  logic                       rd_err_i,
  // write master
  output logic                       wr_start_o,
  output logic [mem_pkg::ADDR_W-1:0] wr_addr_o,
  output mem_pkg::size_t             wr_size_o,
  output logic [mem_pkg::XLEN-1:0]   wr_data_o,
  output logic [mem_pkg::STRB_W-1:0] wr_strb_o,
  input  logic                       wr_done_i,
  input  logic                       wr_err_i
);
  import mem_pkg::*;

  typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_e;

  arb_state_e        state_q;
  logic              gnt_data_q;  // owner of the transaction in flight
  logic              sel_data;
  logic              start;
  logic              data_owns;
  logic              fetch_owns;
  logic [ADDR_W-1:0] req_addr;

  // data port wins when both are waiting, then the grant is held until done
  assign sel_data = (state_q == ARB_BUSY) ? gnt_data_q : data_req_valid_i;
  assign start    = (state_q == ARB_IDLE) & (fetch_req_valid_i | data_req_valid_i);
  assign req_addr = sel_data ? data_addr_i : fetch_addr_i;

  assign rd_start_o = start & ~(sel_data & data_we_i);
  assign rd_addr_o  = req_addr;
  assign rd_size_o  = sel_data ? data_size_i : SIZE_WORD;  // fetch is always a word
  assign rd_id_o    = sel_data ? ID_DATA : ID_FETCH;

  // only the data port writes
  assign wr_start_o = start & sel_data & data_we_i;
  assign wr_addr_o  = req_addr;
  assign wr_size_o  = data_size_i;
  assign wr_data_o  = data_wdata_i;
  assign wr_strb_o  = data_wstrb_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= ARB_IDLE;
      gnt_data_q <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (start) begin
            state_q    <= ARB_BUSY;
            gnt_data_q <= data_req_valid_i;
          end
        end
        ARB_BUSY: begin
          if (rd_done_i | wr_done_i) state_q <= ARB_IDLE;  // back to idle next cycle
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  assign data_owns  = (state_q == ARB_BUSY) & gnt_data_q;
  assign fetch_owns = (state_q == ARB_BUSY) & ~gnt_data_q;

  // master done goes straight back to the granted port
  assign fetch_done_o  = fetch_owns & rd_done_i;
  assign fetch_rdata_o = fetch_done_o ? rd_data_i : '0;
  assign fetch_err_o   = fetch_done_o & rd_err_i;

  assign data_done_o  = data_owns & (rd_done_i | wr_done_i);
  assign data_rdata_o = (data_owns & rd_done_i) ? rd_data_i : '0;
  assign data_err_o   = data_owns & ((rd_done_i & rd_err_i) | (wr_done_i & wr_err_i));

endmodule

// File: rtl/axi_read_master.sv
module axi_read_master (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       rd_start_i,
  input  logic [mem_pkg::ADDR_W-1:0] rd_addr_i,
  input  mem_pkg::size_t             rd_size_i,
  input  mem_pkg::req_id_t           rd_id_i,
  output logic                       rd_done_o,
  output logic [mem_pkg::XLEN-1:0]   rd_data_o,
  output logic                       rd_err_o,
  // read address channel
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  output logic [mem_pkg::ADDR_W-1:0] m_araddr_o,
  output logic [axi_pkg::ID_W-1:0]   m_arid_o,
  output axi_pkg::len_t              m_arlen_o,
  output mem_pkg::size_t             m_arsize_o,
  output axi_pkg::burst_t            m_arburst_o,
  // read data channel
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o,
  input  logic [mem_pkg::XLEN-1:0]   m_rdata_i,
  input  axi_pkg::resp_t             m_rresp_i,
  input  logic                       m_rlast_i,
  input  logic [axi_pkg::ID_W-1:0]   m_rid_i
);
  import axi_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

  rd_state_e state_q;

  assign m_arlen_o   = BEATS_ONE;  // single beat only
  assign m_arburst_o = BURST_INCR;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= RD_IDLE;
      m_arvalid_o <= 1'b0;
      m_rready_o  <= 1'b0;
      rd_done_o   <= 1'b0;
    end else begin
      rd_done_o <= 1'b0;
      case (state_q)
        RD_IDLE: begin
          if (rd_start_i) begin
            m_arvalid_o <= 1'b1;
            state_q     <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (m_arready_i) begin
            m_arvalid_o <= 1'b0;
            m_rready_o  <= 1'b1;  // open R the cycle after AR is taken
            state_q     <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (m_rvalid_i) begin
            m_rready_o <= 1'b0;
            rd_done_o  <= 1'b1;
            state_q    <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start_i) begin
      m_araddr_o <= rd_addr_i;
      m_arsize_o <= rd_size_i;
      m_arid_o   <= rd_id_i;
    end
    if (m_rvalid_i && m_rready_o) begin
      rd_data_o <= m_rdata_i;
      // bad response, missing last or a foreign id all count as an error
      rd_err_o  <= (m_rresp_i != RESP_OKAY) | ~m_rlast_i | (m_rid_i != m_arid_o);
    end
  end

endmodule

// File: rtl/axi_write_master.sv
module axi_write_master (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       wr_start_i,
  input  logic [mem_pkg::ADDR_W-1:0] wr_addr_i,
  input  mem_pkg::size_t             wr_size_i,
  input  logic [mem_pkg::XLEN-1:0]   wr_data_i,
  input  logic [mem_pkg::STRB_W-1:0] wr_strb_i,
  output logic                       wr_done_o,
  output logic                       wr_err_o,
  // write address channel
  output logic                       m_awvalid_o,
  input  logic                       m_awready_i,
  output logic [mem_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic [axi_pkg::ID_W-1:0]   m_awid_o,
  output axi_pkg::len_t              m_awlen_o,
  output mem_pkg::size_t             m_awsize_o,
  output axi_pkg::burst_t            m_awburst_o,
  // write data channel
  output logic                       m_wvalid_o,
  input  logic                       m_wready_i,
  output logic [mem_pkg::XLEN-1:0]   m_wdata_o,
  output logic [mem_pkg::STRB_W-1:0] m_wstrb_o,
  output logic                       m_wlast_o,
  // write response channel
  input  logic                       m_bvalid_i,
  output logic                       m_bready_o,
  input  axi_pkg::resp_t             m_bresp_i,
  input  logic [axi_pkg::ID_W-1:0]   m_bid_i
);
  import axi_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR_DATA, WR_RESP} wr_state_e;

  wr_state_e state_q;
  logic      aw_left;  // AW still waiting after this cycle
  logic      w_left;

  assign aw_left = m_awvalid_o & ~m_awready_i;
  assign w_left  = m_wvalid_o & ~m_wready_i;

  assign m_awid_o    = ID_DATA;  // fetch never writes
  assign m_awlen_o   = BEATS_ONE;
  assign m_awburst_o = BURST_INCR;
  assign m_wlast_o   = 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= WR_IDLE;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
      m_bready_o  <= 1'b0;
      wr_done_o   <= 1'b0;
    end else begin
      wr_done_o <= 1'b0;
      case (state_q)
        WR_IDLE: begin
          if (wr_start_i) begin
            m_awvalid_o <= 1'b1;
            m_wvalid_o  <= 1'b1;
            state_q     <= WR_ADDR_DATA;
          end
        end
        WR_ADDR_DATA: begin
          // slave may take AW and W in either order
          m_awvalid_o <= aw_left;
          m_wvalid_o  <= w_left;
          if (!aw_left && !w_left) begin
            m_bready_o <= 1'b1;
            state_q    <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (m_bvalid_i) begin
            m_bready_o <= 1'b0;
            wr_done_o  <= 1'b1;
            state_q    <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_start_i) begin
      m_awaddr_o <= wr_addr_i;
      m_awsize_o <= wr_size_i;
      m_wdata_o  <= wr_data_i;
      m_wstrb_o  <= wr_strb_i;
    end
    if (m_bvalid_i && m_bready_o) begin
      wr_err_o <= (m_bresp_i != RESP_OKAY) | (m_bid_i != m_awid_o);
    end
  end

endmodule

// File: rtl/core_mem_top.sv
module core_mem_top (
  input  logic                       clk,
  input  logic                       rst_n_i,
  // fetch port
  input  logic                       fetch_req_valid_i,
  input  logic [mem_pkg::ADDR_W-1:0] fetch_addr_i,
  output logic                       fetch_done_o,
  output logic [mem_pkg::XLEN-1:0]   fetch_rdata_o,
  output logic                       fetch_err_o,
  // data port
  input  logic                       data_req_valid_i,
  input  logic                       data_we_i,
  input  logic [mem_pkg::ADDR_W-1:0] data_addr_i,
  input  mem_pkg::size_t             data_size_i,
  input  logic [mem_pkg::XLEN-1:0]   data_wdata_i,
  input  logic [mem_pkg::STRB_W-1:0] data_wstrb_i,
  output logic                       data_done_o,
  output logic [mem_pkg::XLEN-1:0]   data_rdata_o,
  output logic                       data_err_o,
  // AXI4 master, AR
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  output logic [mem_pkg::ADDR_W-1:0] m_araddr_o,
  output logic [axi_pkg::ID_W-1:0]   m_arid_o,
  output axi_pkg::len_t              m_arlen_o,
  output mem_pkg::size_t             m_arsize_o,
  output axi_pkg::burst_t            m_arburst_o,
  // R
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o,
  input  logic [mem_pkg::XLEN-1:0]   m_rdata_i,
  input  axi_pkg::resp_t             m_rresp_i,
  input  logic                       m_rlast_i,
  input  logic [axi_pkg::ID_W-1:0]   m_rid_i,
  // AW
  output logic                       m_awvalid_o,
  input  logic                       m_awready_i,
  output logic [mem_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic [axi_pkg::ID_W-1:0]   m_awid_o,
  output axi_pkg::len_t              m_awlen_o,
  output mem_pkg::size_t             m_awsize_o,
  output axi_pkg::burst_t            m_awburst_o,
  // W
  output logic                       m_wvalid_o,
  input  logic                       m_wready_i,
  output logic [mem_pkg::XLEN-1:0]   m_wdata_o,
  output logic [mem_pkg::STRB_W-1:0] m_wstrb_o,
  output logic                       m_wlast_o,
  // B
  input  logic                       m_bvalid_i,
  output logic                       m_bready_o,
  input  axi_pkg::resp_t             m_bresp_i,
  input  logic [axi_pkg::ID_W-1:0]   m_bid_i
);
  import mem_pkg::*;

  // arbiter to read master
  logic              rd_start;
  logic [ADDR_W-1:0] rd_addr;
  size_t             rd_size;
  req_id_t           rd_id;
  logic              rd_done;
  logic [XLEN-1:0]   rd_data;
  logic              rd_err;

  // arbiter to write master
  logic              wr_start;
  logic [ADDR_W-1:0] wr_addr;
  size_t             wr_size;
  logic [XLEN-1:0]   wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic              wr_done;
  logic              wr_err;

  // requester ports and clock/reset connect by name
  mem_port_arb u_arb (
    .*,
    .rd_start_o (rd_start),
    .rd_addr_o  (rd_addr),
    .rd_size_o  (rd_size),
    .rd_id_o    (rd_id),
    .rd_done_i  (rd_done),
    .rd_data_i  (rd_data),
    .rd_err_i   (rd_err),
    .wr_start_o (wr_start),
    .wr_addr_o  (wr_addr),
    .wr_size_o  (wr_size),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb),
    .wr_done_i  (wr_done),
    .wr_err_i   (wr_err)
  );

  axi_read_master u_rd (
    .*,
    .rd_start_i (rd_start),
    .rd_addr_i  (rd_addr),
    .rd_size_i  (rd_size),
    .rd_id_i    (rd_id),
    .rd_done_o  (rd_done),
    .rd_data_o  (rd_data),
    .rd_err_o   (rd_err)
  );

  axi_write_master u_wr (
    .*,
    .wr_start_i (wr_start),
    .wr_addr_i  (wr_addr),
    .wr_size_i  (wr_size),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .wr_done_o  (wr_done),
    .wr_err_o   (wr_err)
  );

endmodule

// File: sim/core_mem_top_asserts.sv
module core_mem_top_asserts (
  input logic                       clk,
  input logic                       rst_n_i,
  input logic                       fetch_req_valid_i,
  input logic                       data_req_valid_i,
  input mem_pkg::size_t             data_size_i,
  input logic                       fetch_done_o,
  input logic                       data_done_o,
  input logic                       m_arvalid_o,
  input logic                       m_arready_i,
  input logic [mem_pkg::ADDR_W-1:0] m_araddr_o,
  input logic [axi_pkg::ID_W-1:0]   m_arid_o,
  input axi_pkg::len_t              m_arlen_o,
  input mem_pkg::size_t             m_arsize_o,
  input axi_pkg::burst_t            m_arburst_o,
  input logic                       m_rvalid_i,
  input logic                       m_rready_o,
  input logic                       m_awvalid_o,
  input logic                       m_awready_i,
  input logic [mem_pkg::ADDR_W-1:0] m_awaddr_o,
  input logic [axi_pkg::ID_W-1:0]   m_awid_o,
  input axi_pkg::len_t              m_awlen_o,
  input mem_pkg::size_t             m_awsize_o,
  input axi_pkg::burst_t            m_awburst_o,
  input logic                       m_wvalid_o,
  input logic                       m_wready_i,
  input logic [mem_pkg::XLEN-1:0]   m_wdata_o,
  input logic [mem_pkg::STRB_W-1:0] m_wstrb_o,
  input logic                       m_wlast_o,
  input logic                       m_bvalid_i,
  input logic                       m_bready_o
);
  import axi_pkg::*;
  import mem_pkg::*;

  logic proto_err = 1'b0;  // sticky, watched by the testbench
  logic r_owed_q;          // AR taken, R still to come
  logic b_owed_q;          // AW taken, B still to come

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      r_owed_q <= 1'b0;
      b_owed_q <= 1'b0;
    end else begin
      if (m_arvalid_o && m_arready_i) r_owed_q <= 1'b1;
      else if (m_rvalid_i && m_rready_o) r_owed_q <= 1'b0;
      if (m_awvalid_o && m_awready_i) b_owed_q <= 1'b1;
      else if (m_bvalid_i && m_bready_o) b_owed_q <= 1'b0;
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o) &&
                                    $stable(m_arid_o) && $stable(m_arsize_o))
    else begin
      $error("AR valid or payload changed before arready");
      proto_err = 1'b1;
    end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o) && $stable(m_awsize_o))
    else begin
      $error("AW valid or payload changed before awready");
      proto_err = 1'b1;
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o) && $stable(m_wstrb_o))
    else begin
      $error("W valid or payload changed before wready");
      proto_err = 1'b1;
    end

  // single beat bursts only
  len_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
    (!m_arvalid_o || m_arlen_o == BEATS_ONE) && (!m_awvalid_o || m_awlen_o == BEATS_ONE))
    else begin
      $error("burst length other than one beat");
      proto_err = 1'b1;
    end

  // fetch reads are always a word, data reads carry the requested size
  ar_fields: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_arvalid_o |-> m_arburst_o == BURST_INCR &&
                    m_arsize_o == ((m_arid_o == ID_FETCH) ? SIZE_WORD : data_size_i))
    else begin
      $error("AR burst or size does not match the request");
      proto_err = 1'b1;
    end

  aw_fields: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_awvalid_o |-> m_awburst_o == BURST_INCR && m_awid_o == ID_DATA &&
                    m_awsize_o == data_size_i)
    else begin
      $error("AW burst, id or size does not match the request");
      proto_err = 1'b1;
    end

  wlast_set: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_wvalid_o |-> m_wlast_o)
    else begin
      $error("single write beat without wlast");
      proto_err = 1'b1;
    end

  arid_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_arvalid_o |-> (m_arid_o == ID_FETCH && fetch_req_valid_i) ||
                    (m_arid_o == ID_DATA && data_req_valid_i))
    else begin
      $error("arid does not match a waiting port");
      proto_err = 1'b1;
    end

  one_in_flight: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(m_arvalid_o) || $rose(m_awvalid_o) |-> !r_owed_q && !b_owed_q)
    else begin
      $error("new address issued while a response is outstanding");
      proto_err = 1'b1;
    end

  done_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(fetch_done_o && data_done_o))
    else begin
      $error("fetch and data done high together");
      proto_err = 1'b1;
    end

endmodule

bind core_mem_top core_mem_top_asserts u_asserts (.*);

// File: sim/core_mem_top_tb.sv
module core_mem_top_tb;
  import mem_pkg::*;
  import axi_pkg::*;

  localparam logic [31:0] ERR_BASE  = 32'hf000_0000;  // slave answers SLVERR from here up
  localparam logic [31:0] FILL_MASK = 32'h5a5a_c3c3;
  localparam int          TIMEOUT   = 300;            // cycles per wait

  logic clk = 1'b0;
  logic rst_n_i = 1'b0;

  // requester side
  logic              fetch_req_valid_i = 1'b0;
  logic [ADDR_W-1:0] fetch_addr_i = '0;
  logic              fetch_done_o;
  logic [XLEN-1:0]   fetch_rdata_o;
  logic              fetch_err_o;
  logic              data_req_valid_i = 1'b0;
  logic              data_we_i = 1'b0;
  logic [ADDR_W-1:0] data_addr_i = '0;
  size_t             data_size_i = SIZE_WORD;
  logic [XLEN-1:0]   data_wdata_i = '0;
  logic [STRB_W-1:0] data_wstrb_i = '0;
  logic              data_done_o;
  logic [XLEN-1:0]   data_rdata_o;
  logic              data_err_o;

  // AXI, the slave model drives the *_i side
  logic              m_arvalid_o;
  logic              m_arready_i = 1'b0;
  logic [ADDR_W-1:0] m_araddr_o;
  logic [ID_W-1:0]   m_arid_o;
  len_t              m_arlen_o;
  size_t             m_arsize_o;
  burst_t            m_arburst_o;
  logic              m_rvalid_i = 1'b0;
  logic              m_rready_o;
  logic [XLEN-1:0]   m_rdata_i = '0;
  resp_t             m_rresp_i = RESP_OKAY;
  logic              m_rlast_i = 1'b0;
  logic [ID_W-1:0]   m_rid_i = '0;
  logic              m_awvalid_o;
  logic              m_awready_i = 1'b0;
  logic [ADDR_W-1:0] m_awaddr_o;
  logic [ID_W-1:0]   m_awid_o;
  len_t              m_awlen_o;
  size_t             m_awsize_o;
  burst_t            m_awburst_o;
  logic              m_wvalid_o;
  logic              m_wready_i = 1'b0;
  logic [XLEN-1:0]   m_wdata_o;
  logic [STRB_W-1:0] m_wstrb_o;
  logic              m_wlast_o;
  logic              m_bvalid_i = 1'b0;
  logic              m_bready_o;
  resp_t             m_bresp_i = RESP_OKAY;
  logic [ID_W-1:0]   m_bid_i = '0;

  bit [31:0] slave_mem [bit [31:0]];   // keyed by word address
  bit [31:0] shadow_mem [bit [31:0]];

  core_mem_top u_core_mem_top (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] unwritten_word(input logic [31:0] addr);
    return (addr & 32'hffff_fffc) ^ FILL_MASK;
  endfunction

  function automatic logic [31:0] slave_word(input logic [31:0] addr);
    return slave_mem.exists(addr >> 2) ? slave_mem[addr >> 2] : unwritten_word(addr);
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    return shadow_mem.exists(addr >> 2) ? shadow_mem[addr >> 2] : unwritten_word(addr);
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // slave read side, one outstanding read
  logic        rd_pend = 1'b0;
  logic [31:0] rd_addr_q = '0;
  logic [3:0]  rd_id_q = '0;

  always @(posedge clk) begin
    if (!rst_n_i) begin
      m_arready_i <= 1'b0;
      m_rvalid_i  <= 1'b0;
      rd_pend     <= 1'b0;
    end else begin
      m_arready_i <= ($urandom % 3) != 0;
      if (m_arvalid_o && m_arready_i) begin
        rd_pend   <= 1'b1;
        rd_addr_q <= m_araddr_o;
        rd_id_q   <= m_arid_o;
      end
      if (rd_pend && !m_rvalid_i && ($urandom % 2) == 0) begin
        rd_pend    <= 1'b0;
        m_rvalid_i <= 1'b1;
        m_rdata_i  <= slave_word(rd_addr_q);
        m_rresp_i  <= (rd_addr_q >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
        m_rid_i    <= rd_id_q;
        m_rlast_i  <= 1'b1;
      end
      if (m_rvalid_i && m_rready_o) m_rvalid_i <= 1'b0;
    end
  end

  // slave write side, AW and W accepted in any order
  logic        aw_got = 1'b0;
  logic        w_got = 1'b0;
  logic [31:0] aw_addr_q = '0;
  logic [3:0]  aw_id_q = '0;
  logic [31:0] w_data_q = '0;
  logic [3:0]  w_strb_q = '0;

  always @(posedge clk) begin
    if (!rst_n_i) begin
      m_awready_i <= 1'b0;
      m_wready_i  <= 1'b0;
      m_bvalid_i  <= 1'b0;
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
    end else begin
      m_awready_i <= ($urandom % 3) != 0;
      m_wready_i  <= ($urandom % 3) != 0;
      if (m_awvalid_o && m_awready_i) begin
        aw_got    <= 1'b1;
        aw_addr_q <= m_awaddr_o;
        aw_id_q   <= m_awid_o;
      end
      if (m_wvalid_o && m_wready_i) begin
        w_got    <= 1'b1;
        w_data_q <= m_wdata_o;
        w_strb_q <= m_wstrb_o;
      end
      if (aw_got && w_got && !m_bvalid_i && ($urandom % 2) == 0) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        if (aw_addr_q < ERR_BASE) begin
          slave_mem[aw_addr_q >> 2] = merge_lanes(slave_word(aw_addr_q), w_data_q, w_strb_q);
        end
        m_bvalid_i <= 1'b1;
        m_bresp_i  <= (aw_addr_q >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
        m_bid_i    <= aw_id_q;
      end
      if (m_bvalid_i && m_bready_o) m_bvalid_i <= 1'b0;
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    abort_run();
  endtask

  // the bound checker raises this flag when one of its properties fails
  always @(negedge clk) begin
    if (u_core_mem_top.u_asserts.proto_err) begin
      $display("a bound AXI protocol assertion failed at %0t", $time);
      abort_run();
    end
  end

  task automatic wait_done(input bit on_data);
    int  n;
    bit  hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      hit = on_data ? data_done_o : fetch_done_o;
    end
    if (!hit) begin
      $display("timed out waiting for the %s port to finish", on_data ? "data" : "fetch");
      abort_run();
    end
  endtask

  task automatic check_fetch(input logic [31:0] addr);
    if (addr >= ERR_BASE) begin
      assert (fetch_err_o) else report_mismatch($sformatf("fetch %h gave no error", addr));
    end else begin
      assert (!fetch_err_o && fetch_rdata_o == shadow_word(addr))
        else report_mismatch($sformatf("fetch %h read %h err %b, expected %h", addr,
                                       fetch_rdata_o, fetch_err_o, shadow_word(addr)));
    end
  endtask

  task automatic check_data(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
    if (addr >= ERR_BASE) begin
      assert (data_err_o) else report_mismatch($sformatf("data %h gave no error", addr));
    end else begin
      assert (!data_err_o) else report_mismatch($sformatf("data %h flagged an error", addr));
      if (we) begin
        shadow_mem[addr >> 2] = merge_lanes(shadow_word(addr), wdata, wstrb);
      end else begin
        assert (data_rdata_o == shadow_word(addr))
          else report_mismatch($sformatf("data read %h gave %h, expected %h", addr,
                                         data_rdata_o, shadow_word(addr)));
      end
    end
  endtask

  task automatic do_fetch(input logic [31:0] addr);
    @(posedge clk);
    fetch_req_valid_i <= 1'b1;
    fetch_addr_i      <= addr;
    wait_done(1'b0);
    check_fetch(addr);
    @(posedge clk);
    fetch_req_valid_i <= 1'b0;
  endtask

  task automatic do_data(input logic we, input logic [31:0] addr, input size_t size,
                         input logic [31:0] wdata, input logic [3:0] wstrb);
    @(posedge clk);
    data_req_valid_i <= 1'b1;
    data_we_i        <= we;
    data_addr_i      <= addr;
    data_size_i      <= size;
    data_wdata_i     <= wdata;
    data_wstrb_i     <= wstrb;
    wait_done(1'b1);
    check_data(we, addr, wdata, wstrb);
    @(posedge clk);
    data_req_valid_i <= 1'b0;
  endtask

  // both ports raised together, data must finish first
  task automatic race_ports(input logic [31:0] faddr, input logic [31:0] daddr);
    bit data_seen;
    bit fetch_seen;
    int n;
    data_seen  = 1'b0;
    fetch_seen = 1'b0;
    n          = 0;
    @(posedge clk);
    fetch_req_valid_i <= 1'b1;
    fetch_addr_i      <= faddr;
    data_req_valid_i  <= 1'b1;
    data_we_i         <= 1'b0;
    data_addr_i       <= daddr;
    data_size_i       <= SIZE_WORD;
    while (!fetch_seen && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      if (data_done_o) begin
        data_seen = 1'b1;
        check_data(1'b0, daddr, '0, '0);
      end
      if (fetch_done_o) begin
        assert (data_seen) else report_mismatch("fetch port finished ahead of the data port");
        check_fetch(faddr);
        fetch_seen = 1'b1;
      end
      @(posedge clk);
      if (data_seen) data_req_valid_i <= 1'b0;
      if (fetch_seen) fetch_req_valid_i <= 1'b0;
    end
    if (!fetch_seen) begin
      $display("timed out waiting for both ports to finish");
      abort_run();
    end
  endtask

  initial begin
    logic [31:0] addr;
    logic [3:0]  strb;
    int unsigned pick;
    void'($urandom(69));
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;

    do_fetch(32'h0000_0100);
    do_data(1'b1, 32'h0000_0102, SIZE_BYTE, 32'h00ab_0000, 4'b0100);
    do_data(1'b0, 32'h0000_0100, SIZE_WORD, '0, '0);
    do_data(1'b1, 32'h0000_0104, SIZE_HALF, 32'hbeef_0000, 4'b1100);
    do_data(1'b0, 32'h0000_0104, SIZE_WORD, '0, '0);
    do_fetch(32'h0000_0104);
    do_fetch(32'hf000_0010);
    do_data(1'b1, 32'hf000_0020, SIZE_WORD, 32'h1234_5678, 4'b1111);
    do_data(1'b0, 32'hf000_0020, SIZE_WORD, '0, '0);
    race_ports(32'h0000_0200, 32'h0000_0100);

    for (int i = 0; i < 60; i++) begin
      addr = $urandom & 32'h0000_03fc;
      strb = 4'($urandom);
      pick = $urandom % 5;
      case (pick)
        0: do_fetch(addr);
        1: do_data(1'b0, addr, SIZE_WORD, '0, '0);
        2: do_data(1'b1, addr, SIZE_WORD, $urandom, strb);
        3: race_ports(addr, addr ^ 32'h0000_0040);
        default: do_fetch(addr | ERR_BASE);
      endcase
    end

    repeat (5) @(posedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

// File: core_mem_top.f
rtl/axi_pkg.sv
rtl/mem_pkg.sv
rtl/mem_port_arb.sv
rtl/axi_read_master.sv
rtl/axi_write_master.sv
rtl/core_mem_top.sv
sim/core_mem_top_asserts.sv
sim/core_mem_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core_mem_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module core_mem_top_tb \
  -f core_mem_top.f \
  --Mdir obj_dir -o core_mem_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# let assertion errors reach the testbench monitor instead of stopping at once
out=$(./obj_dir/core_mem_top_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
  exit 0
fi
exit 1
